// ==== hdl/eeprom_pkg.sv ====
package eeprom_pkg;

  // ==========================================================
  // device and register constants
  // ==========================================================

  localparam logic [6:0] eeprom_dev_id    = 7'b1010000;
  localparam logic [7:0] counter_reg_addr = 8'd1;

  // ==========================================================
  // transaction interface
  // ==========================================================

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } i2c_op_e;

  typedef struct packed {
    i2c_op_e    op;
    logic [7:0] reg_addr;
    logic [7:0] wr_data;  // ignored on reads.
  } i2c_req_t;

  typedef struct packed {
    logic [7:0] rd_data;
    logic       nack;     // any address or data byte left unacked.
  } i2c_rsp_t;

  // address byte, first on the wire after START.
  typedef struct packed {
    logic [6:0] dev_id;
    logic       rw;       // 1 for read.
  } i2c_addr_fields_t;

  typedef union packed {
    logic [7:0]       raw;
    i2c_addr_fields_t f;
  } i2c_addr_byte_u;

endpackage

// ==== hdl/key_debounce.sv ====
`timescale 1ns/100ps

module key_debounce #(
  parameter int DEBOUNCE_CYCLES = 500000
) (
  input  logic clk,
  input  logic reset_n,
  input  logic key_in,
  output logic press
);

  localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES + 1) : 1;

  logic             key_meta;
  logic             key_sync;
  logic             key_stable;  // last accepted level.
  logic [CNT_W-1:0] stable_cnt;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_meta   <= 1'b1;
      key_sync   <= 1'b1;
      key_stable <= 1'b1;
      stable_cnt <= '0;
      press      <= 1'b0;
    end else begin
      key_meta <= key_in;
      key_sync <= key_meta;
      press    <= 1'b0;
      if (key_sync == key_stable) begin
        stable_cnt <= '0;  // bounce back, start over.
      end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
        // new level held long enough.
        key_stable <= key_sync;
        stable_cnt <= '0;
        press      <= !key_sync;
      end else begin
        stable_cnt <= stable_cnt + CNT_W'(1);
      end
    end
  end

endmodule

// ==== hdl/i2c_byte_master.sv ====
`timescale 1ns/100ps

module i2c_byte_master #(
  parameter int CLK_DIV = 125
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start,
  input  eeprom_pkg::i2c_req_t req,
  output logic                 done,
  output eeprom_pkg::i2c_rsp_t rsp,
  output logic                 scl,
  inout  wire                  sda
);

  import eeprom_pkg::*;

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  typedef enum logic [2:0] {
    ph_idle, ph_start, ph_byte, ph_ack, ph_restart, ph_stop
  } phase_e;

  // which byte of the transaction is on the wire.
  typedef enum logic [2:0] {
    stg_addr_w, stg_reg, stg_addr_r, stg_rd_data, stg_wr_data
  } stage_e;

  phase_e         phase;
  stage_e         stage;
  logic [DIV_W-1:0] div_cnt;
  logic           tick;
  logic [1:0]     quarter;
  logic [2:0]     bit_cnt;
  logic [7:0]     shreg;
  logic           sda_sample;
  logic           nack_q;
  i2c_req_t       req_q;
  i2c_addr_byte_u addr_wr;
  i2c_addr_byte_u addr_rd;
  logic           scl_high;
  logic           scl_d;
  logic           sda_low_d;
  logic           sda_low;

  assign sda      = sda_low ? 1'b0 : 1'bz;  // open drain.
  assign tick     = (div_cnt == DIV_W'(CLK_DIV - 1));
  assign scl_high = (quarter == 2'd1) || (quarter == 2'd2);

  always_comb begin
    addr_wr.f.dev_id = eeprom_dev_id;
    addr_wr.f.rw     = 1'b0;
    addr_rd          = addr_wr;
    addr_rd.f.rw     = 1'b1;
  end

  // ==========================================================
  // bus levels per phase and quarter
  // ==========================================================

  always_comb begin
    scl_d     = 1'b1;
    sda_low_d = 1'b0;
    case (phase)
      ph_start, ph_restart: begin
        scl_d     = scl_high || (quarter == 2'd0 && phase == ph_start);
        sda_low_d = quarter[1];  // sda falls while scl high.
      end
      ph_byte: begin
        scl_d     = scl_high;
        sda_low_d = (stage != stg_rd_data) && !shreg[7];
      end
      ph_ack: begin
        scl_d     = scl_high;  // slave acks, master nacks read data.
        sda_low_d = 1'b0;
      end
      ph_stop: begin
        scl_d     = (quarter != 2'd0);
        sda_low_d = !quarter[1];
      end
      default: begin
        scl_d     = 1'b1;
        sda_low_d = 1'b0;
      end
    endcase
  end

  // ==========================================================
  // sequencing
  // ==========================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase      <= ph_idle;
      stage      <= stg_addr_w;
      div_cnt    <= '0;
      quarter    <= 2'd0;
      bit_cnt    <= 3'd0;
      shreg      <= 8'h00;
      sda_sample <= 1'b1;
      nack_q     <= 1'b0;
      req_q      <= '0;
      done       <= 1'b0;
      rsp        <= '0;
      scl        <= 1'b1;
      sda_low    <= 1'b0;
    end else begin
      done    <= 1'b0;
      scl     <= scl_d;
      sda_low <= sda_low_d;
      if (phase == ph_idle) begin
        if (start) begin
          phase   <= ph_start;
          stage   <= stg_addr_w;
          div_cnt <= '0;
          quarter <= 2'd0;
          bit_cnt <= 3'd0;
          shreg   <= addr_wr.raw;
          nack_q  <= 1'b0;
          req_q   <= req;
        end
      end else begin
        div_cnt <= tick ? '0 : div_cnt + DIV_W'(1);
        if (tick) begin
          quarter <= quarter + 2'd1;
          if (quarter == 2'd1) sda_sample <= sda;  // middle of scl high.
          if (quarter == 2'd3) begin
            case (phase)
              ph_start, ph_restart: begin
                phase   <= ph_byte;
                bit_cnt <= 3'd0;
              end
              ph_byte: begin
                shreg   <= {shreg[6:0], sda_sample};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) phase <= ph_ack;
              end
              ph_ack: begin
                if (sda_sample && stage != stg_rd_data) begin
                  nack_q <= 1'b1;  // give up, straight to stop.
                  phase  <= ph_stop;
                end else begin
                  case (stage)
                    stg_addr_w: begin
                      stage <= stg_reg;
                      shreg <= req_q.reg_addr;
                      phase <= ph_byte;
                    end
                    stg_reg: begin
                      if (req_q.op == op_read) begin
                        stage <= stg_addr_r;
                        shreg <= addr_rd.raw;
                        phase <= ph_restart;
                      end else begin
                        stage <= stg_wr_data;
                        shreg <= req_q.wr_data;
                        phase <= ph_byte;
                      end
                    end
                    stg_addr_r: begin
                      stage <= stg_rd_data;
                      shreg <= 8'hff;
                      phase <= ph_byte;
                    end
                    default: phase <= ph_stop;
                  endcase
                end
              end
              ph_stop: begin
                phase       <= ph_idle;
                done        <= 1'b1;
                rsp.rd_data <= shreg;
                rsp.nack    <= nack_q;
              end
              default: phase <= ph_idle;
            endcase
          end
        end
      end
    end
  end

endmodule

// ==== hdl/counter_ctrl.sv ====
`timescale 1ns/100ps

module counter_ctrl #(
  parameter int START_DELAY = 1000000
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 press,
  input  logic                 done,
  input  eeprom_pkg::i2c_rsp_t rsp,
  output logic                 start,
  output eeprom_pkg::i2c_req_t req,
  output logic [7:0]           value
);

  import eeprom_pkg::*;

  localparam int DLY_W = (START_DELAY > 0) ? $clog2(START_DELAY + 1) : 1;

  typedef enum logic [1:0] {
    st_delay, st_read, st_wait, st_write
  } state_e;

  state_e           state;
  logic [DLY_W-1:0] delay_cnt;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= st_delay;
      delay_cnt <= '0;
      start     <= 1'b0;
      req       <= '0;
      value     <= 8'hff;
    end else begin
      start <= 1'b0;
      case (state)
        st_delay: begin
          if (delay_cnt == DLY_W'(START_DELAY)) begin
            delay_cnt    <= '0;
            state        <= st_read;
            start        <= 1'b1;
            req.op       <= op_read;
            req.reg_addr <= counter_reg_addr;
          end else begin
            delay_cnt <= delay_cnt + DLY_W'(1);
          end
        end
        st_read: begin
          if (done) begin
            if (rsp.nack) begin
              state <= st_delay;  // no device, retry later.
            end else begin
              value <= rsp.rd_data;
              state <= st_wait;
            end
          end
        end
        st_wait: begin
          if (press) begin
            value        <= value + 8'd1;
            state        <= st_write;
            start        <= 1'b1;
            req.op       <= op_write;
            req.reg_addr <= counter_reg_addr;
            req.wr_data  <= value + 8'd1;
          end
        end
        default: begin
          if (done) begin  // read back after write.
            state        <= st_read;
            start        <= 1'b1;
            req.op       <= op_read;
            req.reg_addr <= counter_reg_addr;
          end
        end
      endcase
    end
  end

endmodule

// ==== hdl/hex_seg_display.sv ====
`timescale 1ns/100ps

module hex_seg_display #(
  parameter int SCAN_CYCLES = 50000
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic [7:0] value,
  output logic [5:0] sel,
  output logic [7:0] seg
);

  localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

  logic [SCAN_W-1:0] scan_cnt;
  logic [5:0]        digit_oh;
  logic [3:0]        nibble;
  logic              blank;

  // active low, {g,f,e,d,c,b,a}.
  function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
    case (hex)
      4'h0: hex_to_seg = 7'h40;
      4'h1: hex_to_seg = 7'h79;
      4'h2: hex_to_seg = 7'h24;
      4'h3: hex_to_seg = 7'h30;
      4'h4: hex_to_seg = 7'h19;
      4'h5: hex_to_seg = 7'h12;
      4'h6: hex_to_seg = 7'h02;
      4'h7: hex_to_seg = 7'h78;
      4'h8: hex_to_seg = 7'h00;
      4'h9: hex_to_seg = 7'h10;
      4'ha: hex_to_seg = 7'h08;
      4'hb: hex_to_seg = 7'h03;
      4'hc: hex_to_seg = 7'h46;
      4'hd: hex_to_seg = 7'h21;
      4'he: hex_to_seg = 7'h06;
      default: hex_to_seg = 7'h0e;
    endcase
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      scan_cnt <= '0;
      digit_oh <= 6'b000001;
    end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
      scan_cnt <= '0;
      digit_oh <= {digit_oh[4:0], digit_oh[5]};  // next digit.
    end else begin
      scan_cnt <= scan_cnt + SCAN_W'(1);
    end
  end

  assign nibble = digit_oh[1] ? value[7:4] : value[3:0];
  assign blank  = !(digit_oh[0] || digit_oh[1]);  // upper four unused.

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sel <= 6'b111111;
      seg <= 8'hff;
    end else begin
      sel <= ~digit_oh;
      seg <= blank ? 8'hff : {1'b1, hex_to_seg(nibble)};  // dp off.
    end
  end

endmodule

// ==== hdl/eeprom_counter_top.sv ====
`timescale 1ns/100ps

module eeprom_counter_top #(
  parameter int START_DELAY     = 1000000,
  parameter int DEBOUNCE_CYCLES = 500000,
  parameter int CLK_DIV         = 125,     // 100 kHz scl from 50 MHz.
  parameter int SCAN_CYCLES     = 50000
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       key_in,
  output logic       scl,
  inout  wire        sda,
  output logic [5:0] sel,
  output logic [7:0] seg
);

  import eeprom_pkg::*;

  logic       press;
  logic       start;
  logic       done;
  i2c_req_t   req;
  i2c_rsp_t   rsp;
  logic [7:0] value;

  key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_key_debounce (
    .clk     (clk),
    .reset_n (reset_n),
    .key_in  (key_in),
    .press   (press)
  );

  counter_ctrl #(.START_DELAY(START_DELAY)) i_counter_ctrl (
    .clk     (clk),
    .reset_n (reset_n),
    .press   (press),
    .done    (done),
    .rsp     (rsp),
    .start   (start),
    .req     (req),
    .value   (value)
  );

  i2c_byte_master #(.CLK_DIV(CLK_DIV)) i_i2c_byte_master (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .req     (req),
    .done    (done),
    .rsp     (rsp),
    .scl     (scl),
    .sda     (sda)
  );

  hex_seg_display #(.SCAN_CYCLES(SCAN_CYCLES)) i_hex_seg_display (
    .clk     (clk),
    .reset_n (reset_n),
    .value   (value),
    .sel     (sel),
    .seg     (seg)
  );

endmodule

// ==== tests/eeprom_model.sv ====
`timescale 1ns/100ps

module eeprom_model (
  input  logic scl,
  inout  wire  sda,
  input  logic present
);

  import eeprom_pkg::*;

  typedef enum int {
    st_idle, st_addr, st_reg, st_wdata, st_rdata, st_wait_stop
  } state_e;

  logic [7:0]     mem [0:255];
  state_e         state       = st_idle;
  int             bit_cnt     = 8;  // 8 is the ack clock.
  int             error_count = 0;
  logic [7:0]     shift       = 8'h00;
  logic [7:0]     tx_byte     = 8'h00;
  logic [7:0]     ptr         = 8'h00;
  logic           active      = 1'b0;
  logic           tx          = 1'b0;
  logic           drive_low   = 1'b0;
  logic           scl_prev;
  logic           sda_prev;
  i2c_addr_byte_u addr_byte;

  assign sda = drive_low ? 1'b0 : 1'bz;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'h5c;
    end
  end

  task automatic preload(input logic [7:0] addr, input logic [7:0] data);
    mem[addr] = data;
  endtask

  // ==========================================================
  // bus decoding
  // ==========================================================

  always @(scl or sda) begin
    if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda === 1'b0) begin
      if (active && state == st_wait_stop) error_count++;  // stop missing.
      active    = present;
      state     = st_addr;
      bit_cnt   = 8;
      tx        = 1'b0;
      drive_low = 1'b0;
    end else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 &&
                 sda === 1'b1) begin
      if (active && state != st_wait_stop) error_count++;  // stop mid byte.
      active    = 1'b0;
      state     = st_idle;
      drive_low = 1'b0;
    end else if (scl_prev === 1'b0 && scl === 1'b1) begin
      if (active && bit_cnt < 8 && !tx) shift = {shift[6:0], (sda !== 1'b0)};
    end else if (scl_prev === 1'b1 && scl === 1'b0 && active) begin
      if (bit_cnt == 8) begin
        bit_cnt   = 0;  // next byte.
        tx        = (state == st_rdata);
        drive_low = tx && !tx_byte[7];
      end else begin
        bit_cnt++;
        if (bit_cnt < 8) begin
          drive_low = tx && !tx_byte[7 - bit_cnt];
        end else begin
          case (state)
            st_addr: begin
              addr_byte.raw = shift;
              if (addr_byte.f.dev_id != eeprom_dev_id) begin
                error_count++;
                state     = st_wait_stop;
                drive_low = 1'b0;
              end else begin
                drive_low = 1'b1;
                if (addr_byte.f.rw) begin
                  state   = st_rdata;
                  tx_byte = mem[ptr];
                end else begin
                  state = st_reg;
                end
              end
            end
            st_reg: begin
              ptr       = shift;
              drive_low = 1'b1;
              state     = st_wdata;
            end
            st_wdata: begin
              mem[ptr]  = shift;
              drive_low = 1'b1;
              state     = st_wait_stop;
            end
            st_rdata: begin
              drive_low = 1'b0;  // master answers.
              state     = st_wait_stop;
            end
            default: drive_low = 1'b0;
          endcase
        end
      end
    end
    scl_prev = scl;
    sda_prev = sda;
  end

endmodule

// ==== tests/i2c_master_asserts.sv ====
`timescale 1ns/100ps

module i2c_master_asserts (
  input logic clk,
  input logic reset_n,
  input logic start,
  input logic done,
  input logic scl
);

  logic busy;
  logic started;
  int   fail_count = 0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy    <= 1'b0;
      started <= 1'b0;
    end else begin
      if (start) begin
        busy    <= 1'b1;
        started <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (!reset_n) start |-> !busy)
    else begin
      fail_count++;
      $error("start while transaction busy");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
    else begin
      fail_count++;
      $error("done held longer than one cycle");
    end

  a_scl_idle: assert property (@(posedge clk) disable iff (!reset_n) !started |-> scl)
    else begin
      fail_count++;
      $error("scl low before first start");
    end

endmodule

bind i2c_byte_master i2c_master_asserts i_master_asserts (
  .clk     (clk),
  .reset_n (reset_n),
  .start   (start),
  .done    (done),
  .scl     (scl)
);

// ==== tests/eeprom_counter_tb.sv ====
`timescale 1ns/100ps

module eeprom_counter_tb;

  localparam int START_DELAY     = 20;
  localparam int DEBOUNCE_CYCLES = 8;
  localparam int CLK_DIV         = 4;
  localparam int SCAN_CYCLES     = 4;
  // 5 tests x 4 transactions x 40 bits x 16 cycles, plus delays.
  localparam int TIMEOUT_CYCLES  = 20000;

  logic       clk;
  logic       reset_n;
  logic       key_in;
  logic       present;
  logic       scl;
  wire        sda;
  logic [5:0] sel;
  logic [7:0] seg;
  int         errors      = 0;
  int         cycles      = 0;
  int         start_count = 0;

  pullup (sda);

  eeprom_counter_top #(
    .START_DELAY     (START_DELAY),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .CLK_DIV         (CLK_DIV),
    .SCAN_CYCLES     (SCAN_CYCLES)
  ) i_dut (
    .clk     (clk),
    .reset_n (reset_n),
    .key_in  (key_in),
    .scl     (scl),
    .sda     (sda),
    .sel     (sel),
    .seg     (seg)
  );

  eeprom_model i_eeprom (
    .scl     (scl),
    .sda     (sda),
    .present (present)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  always @(negedge sda) begin
    if (scl === 1'b1) start_count++;  // start or repeated start.
  end

  // ==========================================================
  // display decoding
  // ==========================================================

  // active high, {g,f,e,d,c,b,a}.
  function automatic logic [6:0] hex_pattern(input logic [3:0] hex);
    case (hex)
      4'h0: hex_pattern = 7'h3f;
      4'h1: hex_pattern = 7'h06;
      4'h2: hex_pattern = 7'h5b;
      4'h3: hex_pattern = 7'h4f;
      4'h4: hex_pattern = 7'h66;
      4'h5: hex_pattern = 7'h6d;
      4'h6: hex_pattern = 7'h7d;
      4'h7: hex_pattern = 7'h07;
      4'h8: hex_pattern = 7'h7f;
      4'h9: hex_pattern = 7'h6f;
      4'ha: hex_pattern = 7'h77;
      4'hb: hex_pattern = 7'h7c;
      4'hc: hex_pattern = 7'h39;
      4'hd: hex_pattern = 7'h5e;
      4'he: hex_pattern = 7'h79;
      default: hex_pattern = 7'h71;
    endcase
  endfunction

  function automatic logic [4:0] seg_to_hex(input logic [7:0] pattern);
    logic [4:0] result;
    int         i;
    result = 5'h00;  // bit 4 set on a match.
    for (i = 0; i < 16; i++) begin
      if (pattern[6:0] == ~hex_pattern(4'(i)) && pattern[7]) result = {1'b1, 4'(i)};
    end
    return result;
  endfunction

  task automatic read_display(output logic [7:0] value);
    logic [4:0] lo;
    logic [4:0] hi;
    int         d;
    @(negedge clk);
    while (sel !== 6'b111110) @(negedge clk);
    lo = seg_to_hex(seg);
    while (sel !== 6'b111101) @(negedge clk);
    hi = seg_to_hex(seg);
    if (!lo[4] || !hi[4]) begin
      errors++;
      $display("%0t: display shows a pattern that is not a hex digit", $time);
    end
    for (d = 2; d < 6; d++) begin  // upper digits stay dark.
      while (sel !== ~(6'b000001 << d)) @(negedge clk);
      if (seg !== 8'hff) begin
        errors++;
        $display("ERR %0t seg: got %02h, expected ff on digit %0d", $time, seg, d);
      end
    end
    value = {hi[3:0], lo[3:0]};
  endtask

  // ==========================================================
  // helpers
  // ==========================================================

  task automatic wait_display(input logic [7:0] expected, input int frames);
    logic [7:0] value;
    int         n;
    n = 0;
    read_display(value);
    while (value !== expected && n < frames) begin
      read_display(value);
      n++;
    end
  endtask

  task automatic wait_mem(input logic [7:0] expected, input int limit);
    int n;
    n = 0;
    while (i_eeprom.mem[1] !== expected && n < limit) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_bus_idle();
    int high;
    high = 0;
    while (high < 64) begin  // longer than any high run inside a transaction.
      @(negedge clk);
      high = (scl === 1'b1) ? high + 1 : 0;
    end
  endtask

  task automatic wait_for_start();
    int n0;
    n0 = start_count;
    while (start_count == n0) @(negedge clk);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset_n = 1'b0;
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
  endtask

  task automatic press_key();
    @(negedge clk);
    key_in = 1'b0;
    repeat (DEBOUNCE_CYCLES + 6) @(negedge clk);
    key_in = 1'b1;
    repeat (DEBOUNCE_CYCLES + 6) @(negedge clk);
  endtask

  task automatic glitch_key();
    int width;
    width = 1 + int'($urandom % (DEBOUNCE_CYCLES - 2));
    @(negedge clk);
    key_in = 1'b0;
    repeat (width) @(negedge clk);
    key_in = 1'b1;
    repeat (DEBOUNCE_CYCLES + 4) @(negedge clk);
  endtask

  // ==========================================================
  // tests
  // ==========================================================

  task automatic test_reset();
    logic [7:0] shown;
    i_eeprom.preload(8'd1, 8'h3c);
    present = 1'b1;
    @(negedge clk);
    reset_n = 1'b0;
    repeat (8) @(negedge clk);
    if (sel !== 6'b111111) begin
      errors++;
      $display("ERR %0t sel: got %b, expected 111111", $time, sel);
    end
    if (scl !== 1'b1) begin
      errors++;
      $display("ERR %0t scl: got %b, expected 1", $time, scl);
    end
    reset_n = 1'b1;
    @(negedge clk);
    if (scl !== 1'b1) begin
      errors++;
      $display("ERR %0t scl: got %b, expected 1", $time, scl);
    end
    if (sda !== 1'b1) begin
      errors++;
      $display("ERR %0t sda: got %b, expected 1", $time, sda);
    end
    read_display(shown);
    if (shown !== 8'hff) begin
      errors++;
      $display("ERR %0t display: got %02h, expected ff", $time, shown);
    end
  endtask

  task automatic test_power_up();
    logic [7:0] shown;
    wait_display(8'h3c, 100);
    read_display(shown);
    if (shown !== 8'h3c) begin
      errors++;
      $display("ERR %0t display: got %02h, expected 3c", $time, shown);
    end
    if (i_eeprom.error_count != 0) begin
      errors++;
      $display("%0t: model saw %0d protocol errors", $time, i_eeprom.error_count);
    end
  endtask

  task automatic test_increment();
    logic [7:0] shown;
    int         i;
    for (i = 0; i < 5; i++) glitch_key();
    repeat (40 * 4 * CLK_DIV) @(negedge clk);  // room for a stray write to land.
    read_display(shown);
    if (i_eeprom.mem[1] !== 8'h3c) begin
      errors++;
      $display("ERR %0t mem[1]: got %02h, expected 3c", $time, i_eeprom.mem[1]);
    end
    if (shown !== 8'h3c) begin
      errors++;
      $display("ERR %0t display: got %02h, expected 3c", $time, shown);
    end
    press_key();
    wait_mem(8'h3d, 2000);
    wait_bus_idle();
    read_display(shown);
    if (i_eeprom.mem[1] !== 8'h3d) begin
      errors++;
      $display("ERR %0t mem[1]: got %02h, expected 3d", $time, i_eeprom.mem[1]);
    end
    if (shown !== 8'h3d) begin
      errors++;
      $display("ERR %0t display: got %02h, expected 3d", $time, shown);
    end
    for (i = 0; i < 3; i++) begin
      press_key();
      wait_display(8'(8'h3e + i), 100);
      wait_mem(8'(8'h3e + i), 2000);
      wait_bus_idle();
    end
    read_display(shown);
    if (i_eeprom.mem[1] !== 8'h40) begin
      errors++;
      $display("ERR %0t mem[1]: got %02h, expected 40", $time, i_eeprom.mem[1]);
    end
    if (shown !== 8'h40) begin
      errors++;
      $display("ERR %0t display: got %02h, expected 40", $time, shown);
    end
  endtask

  task automatic test_wrap();
    logic [7:0] shown;
    i_eeprom.preload(8'd1, 8'hff);
    apply_reset();
    wait_for_start();
    wait_bus_idle();
    press_key();
    wait_mem(8'h00, 2000);
    wait_bus_idle();
    read_display(shown);
    if (i_eeprom.mem[1] !== 8'h00) begin
      errors++;
      $display("ERR %0t mem[1]: got %02h, expected 00", $time, i_eeprom.mem[1]);
    end
    if (shown !== 8'h00) begin
      errors++;
      $display("ERR %0t display: got %02h, expected 00", $time, shown);
    end
  endtask

  task automatic test_absent();
    logic [7:0] shown;
    int         n0;
    present = 1'b0;
    i_eeprom.preload(8'd1, 8'h5a);
    apply_reset();
    n0 = start_count;
    repeat (700) @(negedge clk);
    read_display(shown);
    if (shown !== 8'hff) begin
      errors++;
      $display("ERR %0t display: got %02h, expected ff", $time, shown);
    end
    if (start_count - n0 < 2) begin
      errors++;
      $display("%0t: no retry seen on the bus while the device was absent", $time);
    end
    @(negedge clk);
    present = 1'b1;
    wait_display(8'h5a, 150);
    read_display(shown);
    if (shown !== 8'h5a) begin
      errors++;
      $display("ERR %0t display: got %02h, expected 5a", $time, shown);
    end
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================

  initial begin
    void'($urandom(32'ha9e1_a963));
    reset_n = 1'b0;
    key_in  = 1'b1;
    present = 1'b1;
    test_reset();
    test_power_up();
    test_increment();
    test_wrap();
    test_absent();
    $display("errors: %0d testbench, %0d model, %0d assertion", errors,
             i_eeprom.error_count, i_dut.i_i2c_byte_master.i_master_asserts.fail_count);
    if (errors == 0 && i_eeprom.error_count == 0 &&
        i_dut.i_i2c_byte_master.i_master_asserts.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/eeprom_pkg.sv
hdl/key_debounce.sv
hdl/i2c_byte_master.sv
hdl/counter_ctrl.sv
hdl/hex_seg_display.sv
hdl/eeprom_counter_top.sv
tests/eeprom_model.sv
tests/i2c_master_asserts.sv
tests/eeprom_counter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= eeprom_counter_tb
FILELIST  ?= filelist.f
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) $(SIMFLAGS)); echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
